// File: hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  typedef logic [3:0] reg_idx_t;

  localparam reg_idx_t pc_reg = 4'd15;

  // ========================================================================
  // Instruction classes and operand encodings
  // ========================================================================

  typedef enum logic [2:0] {
    class_dataproc_imm     = 3'd0,
    class_dataproc_reg_imm = 3'd1,
    class_dataproc_reg_reg = 3'd2,
    class_load             = 3'd3,
    class_store            = 3'd4,
    class_none             = 3'd5
  } instr_class_e;

  typedef enum logic [1:0] {
    shift_lsl = 2'd0,
    shift_lsr = 2'd1,
    shift_asr = 2'd2,
    shift_ror = 2'd3
  } shift_e;

  // Data-processing opcode order, with one extra code for reversed subtract
  typedef enum logic [3:0] {
    alu_and     = 4'd0,
    alu_eor     = 4'd1,
    alu_sub     = 4'd2,
    alu_rsb     = 4'd3,
    alu_add     = 4'd4,
    alu_adc     = 4'd5,
    alu_sbc     = 4'd6,
    alu_rsc     = 4'd7,
    alu_tst     = 4'd8,
    alu_teq     = 4'd9,
    alu_cmp     = 4'd10,
    alu_cmn     = 4'd11,
    alu_orr     = 4'd12,
    alu_mov     = 4'd13,
    alu_sub_rev = 4'd14
  } alu_op_e;

  // ========================================================================
  // Decoded instruction word, 64 bits
  // ========================================================================

  typedef struct packed {
    instr_class_e instr_class;
    logic         condition_pass;
    reg_idx_t     rd;
    reg_idx_t     rn;
    reg_idx_t     rm;
    reg_idx_t     rs;
    alu_op_e      opcode;
    logic         set_flags;
    logic [7:0]   imm8;
    logic [3:0]   rotate;
    shift_e       shift_type;
    logic [4:0]   shift_amount;
    logic [11:0]  imm12;
    logic         p;
    logic         u;
    logic         b;
    logic         w;
    logic         i;
    logic [2:0]   reserved;
  } decoded_word_t;

  // Compare and test opcodes only update the flags
  function automatic logic alu_writes_rd(input alu_op_e op);
    return !(op inside {alu_tst, alu_teq, alu_cmp, alu_cmn});
  endfunction

endpackage

`default_nettype wire

// File: hw/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

  import cpu_isa_pkg::*;

  localparam int step_width        = 2;
  localparam int reset_flush_count = 3;

  // ========================================================================
  // Bus sources, writeback targets and flush phases
  // ========================================================================

  typedef enum logic [1:0] {
    addr_pc   = 2'd0,
    addr_incr = 2'd1,
    addr_alu  = 2'd2
  } addr_src_e;

  typedef enum logic [2:0] {
    bsrc_imm       = 3'd0,
    bsrc_reg_rm    = 3'd1,
    bsrc_reg_rs    = 3'd2,
    bsrc_reg_rd    = 3'd3,
    bsrc_read_data = 3'd4
  } b_src_e;

  typedef enum logic [1:0] {
    wb_none   = 2'd0,
    wb_reg_rd = 2'd1,
    wb_reg_rn = 2'd2
  } alu_wb_e;

  typedef enum logic [1:0] {
    flush_idle    = 2'd0,
    flush_load_pc = 2'd1,
    flush_fetch   = 2'd2,
    flush_refill  = 2'd3
  } flush_phase_e;

  // ========================================================================
  // Datapath control word, one per cycle
  // ========================================================================

  typedef struct packed {
    addr_src_e   addr_src;
    b_src_e      b_src;
    logic [11:0] b_imm;
    // Barrel shifter
    shift_e      shift_type;
    logic [4:0]  shift_amount;
    logic        shift_latch_amt;
    logic        shift_use_latch;
    logic        shift_use_rrx;
    // ALU
    alu_op_e     alu_op;
    alu_wb_e     alu_writeback;
    logic        alu_set_flags;
    logic        alu_latch_op_b;
    logic        alu_disable_op_b;
    logic        alu_use_op_b_latch;
    // Register reads of r15 see the prefetch offset
    logic        pc_rn_add_4;
    logic        pc_rm_add_4;
    logic        pc_rs_add_4;
    // Memory and fetch
    logic        mem_read_en;
    logic        mem_write_en;
    logic        mem_byte;
    logic        instr_fetch_en;
    logic        incr_writeback;
    logic        pipeline_advance;
  } control_t;

endpackage

`default_nettype wire

// File: hw/instr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer
  import cpu_ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush_req,
  input  logic                  pipeline_advance,
  output logic [step_width-1:0] step,
  output flush_phase_e          flush_phase
);

  logic [1:0] flush_count;

  // Reset starts the full start-up flush, a request only the refill part
  always_ff @(posedge clk) begin
    if (reset) begin
      flush_count <= 2'(reset_flush_count);
    end else if (flush_req) begin
      flush_count <= 2'd1;
    end else if (flush_count != 2'd0) begin
      flush_count <= flush_count - 2'd1;
    end
  end

  always_comb begin
    case (flush_count)
      2'd3:    flush_phase = flush_load_pc;
      2'd2:    flush_phase = flush_fetch;
      2'd1:    flush_phase = flush_refill;
      default: flush_phase = flush_idle;
    endcase
  end

  // Step within the current instruction
  always_ff @(posedge clk) begin
    if (reset || pipeline_advance) begin
      step <= '0;
    end else begin
      step <= step + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/dataproc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dataproc_ctrl
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  decoded_word_t         word,
  input  logic [step_width-1:0] step,
  output control_t              ctrl
);

  logic final_step;

  always_comb begin
    ctrl       = '0;
    final_step = 1'b0;

    case (word.instr_class)
      // Rotated 8-bit immediate, single cycle
      class_dataproc_imm: begin
        ctrl.b_src        = bsrc_imm;
        ctrl.b_imm        = {4'd0, word.imm8};
        ctrl.shift_type   = shift_ror;
        ctrl.shift_amount = {word.rotate, 1'b0};
        final_step        = 1'b1;
      end

      class_dataproc_reg_imm: begin
        ctrl.b_src        = bsrc_reg_rm;
        ctrl.shift_type   = word.shift_type;
        ctrl.shift_amount = word.shift_amount;
        // ror #0 encodes rrx
        ctrl.shift_use_rrx = (word.shift_type == shift_ror) && (word.shift_amount == 5'd0);
        final_step         = 1'b1;
      end

      // Step 0 reads rs into the shift latch, step 1 does the operation
      class_dataproc_reg_reg: begin
        if (step == 2'd0) begin
          ctrl.b_src           = bsrc_reg_rs;
          ctrl.shift_latch_amt = 1'b1;
          ctrl.pc_rs_add_4     = (word.rs == pc_reg);
        end else if (step == 2'd1) begin
          ctrl.b_src           = bsrc_reg_rm;
          ctrl.shift_type      = word.shift_type;
          ctrl.shift_use_latch = 1'b1;
          ctrl.pc_rn_add_4     = (word.rn == pc_reg);
          ctrl.pc_rm_add_4     = (word.rm == pc_reg);
          final_step           = 1'b1;
        end
      end

      default: ;
    endcase

    // The ALU result is only valid on the last step
    if (final_step) begin
      ctrl.alu_op           = word.opcode;
      ctrl.alu_set_flags    = word.set_flags;
      ctrl.alu_writeback    = alu_writes_rd(word.opcode) ? wb_reg_rd : wb_none;
      ctrl.pipeline_advance = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/load_store_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_ctrl
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  decoded_word_t         word,
  input  logic [step_width-1:0] step,
  output control_t              ctrl
);

  logic    is_ls;
  logic    base_writeback;
  alu_op_e offset_op;

  assign is_ls          = (word.instr_class == class_load) || (word.instr_class == class_store);
  // Post-indexed always updates the base, pre-indexed only with w
  assign base_writeback = !word.p || word.w;
  assign offset_op      = word.u ? alu_add : alu_sub;

  always_comb begin
    ctrl = '0;

    if (is_ls) begin
      // ====================================================================
      // Step 0 computes the address
      // ====================================================================
      if (step == 2'd0) begin
        ctrl.alu_op   = offset_op;
        ctrl.addr_src = addr_alu;

        if (!word.i) begin
          ctrl.b_src = bsrc_imm;
          ctrl.b_imm = word.imm12;
        end else begin
          ctrl.b_src         = bsrc_reg_rm;
          ctrl.shift_type    = word.shift_type;
          ctrl.shift_amount  = word.shift_amount;
          ctrl.shift_use_rrx = (word.shift_type == shift_ror) && (word.shift_amount == 5'd0);
        end

        if (word.p) begin
          ctrl.alu_latch_op_b = word.w;
        end else begin
          // Post-indexed uses the bare base as address and keeps the offset
          ctrl.alu_disable_op_b = 1'b1;
          ctrl.alu_latch_op_b   = 1'b1;
        end

      // ====================================================================
      // Step 1 does the access and the base update
      // ====================================================================
      end else if (step == 2'd1) begin
        ctrl.alu_op   = offset_op;
        ctrl.mem_byte = word.b;
        ctrl.addr_src = addr_pc;

        if (base_writeback) begin
          ctrl.alu_use_op_b_latch = 1'b1;
          ctrl.alu_writeback      = wb_reg_rn;
        end

        if (word.instr_class == class_load) begin
          ctrl.mem_read_en = 1'b1;
        end else begin
          ctrl.mem_write_en     = 1'b1;
          ctrl.b_src            = bsrc_reg_rd;
          ctrl.pipeline_advance = 1'b1;
        end

      // Load only, read data passes through the ALU into rd
      end else if (step == 2'd2 && word.instr_class == class_load) begin
        ctrl.alu_op           = alu_mov;
        ctrl.b_src            = bsrc_read_data;
        ctrl.alu_writeback    = wb_reg_rd;
        ctrl.mem_byte         = word.b;
        ctrl.addr_src         = addr_pc;
        ctrl.pipeline_advance = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/control_select.sv
`timescale 1ns/1ps
`default_nettype none

module control_select
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  decoded_word_t word,
  input  flush_phase_e  flush_phase,
  input  logic          flush_req,
  input  control_t      dp_ctrl,
  input  control_t      ls_ctrl,
  output control_t      control_signals
);

  always_comb begin
    control_signals = '0;

    if (flush_phase == flush_load_pc) begin
      control_signals.addr_src = addr_pc;
    end else if (flush_phase == flush_fetch || flush_req) begin
      control_signals.instr_fetch_en = 1'b1;
      control_signals.incr_writeback = 1'b1;
      control_signals.addr_src       = addr_incr;
    end else if (flush_phase == flush_refill) begin
      control_signals.instr_fetch_en   = 1'b1;
      control_signals.incr_writeback   = 1'b1;
      control_signals.addr_src         = addr_pc;
      control_signals.pipeline_advance = 1'b1;
    end else if (!word.condition_pass) begin
      // Skipped instruction, just move on to the next one
      control_signals.instr_fetch_en   = 1'b1;
      control_signals.incr_writeback   = 1'b1;
      control_signals.addr_src         = addr_pc;
      control_signals.pipeline_advance = 1'b1;
    end else begin
      case (word.instr_class)
        class_dataproc_imm, class_dataproc_reg_imm, class_dataproc_reg_reg: begin
          control_signals = dp_ctrl;
          if (dp_ctrl.pipeline_advance) begin
            control_signals.instr_fetch_en = 1'b1;
            control_signals.incr_writeback = 1'b1;
            control_signals.addr_src       = addr_pc;
          end
        end

        class_load, class_store: begin
          control_signals = ls_ctrl;
          // Only the address step drives the address bus from the ALU
          if (ls_ctrl.addr_src == addr_alu) begin
            control_signals.instr_fetch_en = 1'b1;
            control_signals.incr_writeback = 1'b1;
          end
        end

        default: control_signals = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  decoded_word_t word,
  input  logic          flush_req,
  output control_t      control_signals
);

  logic [step_width-1:0] step;
  flush_phase_e          flush_phase;
  control_t              dp_ctrl;
  control_t              ls_ctrl;

  instr_sequencer instr_sequencer_inst (
    .clk              (clk),
    .reset            (reset),
    .flush_req        (flush_req),
    .pipeline_advance (control_signals.pipeline_advance),
    .step             (step),
    .flush_phase      (flush_phase)
  );

  dataproc_ctrl dataproc_ctrl_inst (
    .word (word),
    .step (step),
    .ctrl (dp_ctrl)
  );

  load_store_ctrl load_store_ctrl_inst (
    .word (word),
    .step (step),
    .ctrl (ls_ctrl)
  );

  control_select control_select_inst (
    .word            (word),
    .flush_phase     (flush_phase),
    .flush_req       (flush_req),
    .dp_ctrl         (dp_ctrl),
    .ls_ctrl         (ls_ctrl),
    .control_signals (control_signals)
  );

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  localparam int half_period_ns = 5;
  localparam int reset_cycles   = 16;

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // Reset drops on a falling edge so it is stable at the next rising edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
();

  localparam int num_words      = 400;
  localparam int clk_period_ns  = 10;
  localparam int timeout_cycles = num_words * 3 + 100;

  logic          clk;
  logic          reset;
  decoded_word_t word;
  logic          flush_req;
  control_t      control_signals;

  integer                seed;
  int                    words_done;
  logic                  advance_seen = 1'b0;
  logic [1:0]            model_flush_count;
  logic [step_width-1:0] model_step;
  int                    startup_cycles;
  logic                  startup_done;

  clock_gen clock_gen_inst (
    .clk   (clk),
    .reset (reset)
  );

  control_unit control_unit_inst (
    .clk             (clk),
    .reset           (reset),
    .word            (word),
    .flush_req       (flush_req),
    .control_signals (control_signals)
  );

  // ==========================================================================
  // Reference model of the control word
  // ==========================================================================

  function automatic control_t expected_ctrl(input decoded_word_t w,
                                             input logic [step_width-1:0] s,
                                             input logic [1:0] fcount,
                                             input logic freq);
    control_t c;
    logic     rrx;
    logic     last;
    logic     base_wb;
    alu_op_e  offset_op;

    c         = '0;
    rrx       = (w.shift_type == shift_ror) && (w.shift_amount == 5'd0);
    base_wb   = !w.p || w.w;
    offset_op = w.u ? alu_add : alu_sub;

    if (fcount == 2'd3) begin
      c.addr_src = addr_pc;
    end else if (fcount == 2'd2 || freq) begin
      c.instr_fetch_en = 1'b1;
      c.incr_writeback = 1'b1;
      c.addr_src       = addr_incr;
    end else if (fcount == 2'd1 || !w.condition_pass) begin
      c.instr_fetch_en   = 1'b1;
      c.incr_writeback   = 1'b1;
      c.addr_src         = addr_pc;
      c.pipeline_advance = 1'b1;
    end else if (w.instr_class inside {class_dataproc_imm, class_dataproc_reg_imm,
                                       class_dataproc_reg_reg}) begin
      last = (w.instr_class != class_dataproc_reg_reg) || (s == 1);
      if (w.instr_class == class_dataproc_imm) begin
        c.b_src        = bsrc_imm;
        c.b_imm        = 12'(w.imm8);
        c.shift_type   = shift_ror;
        c.shift_amount = 5'(2 * w.rotate);
      end else if (w.instr_class == class_dataproc_reg_imm) begin
        c.b_src         = bsrc_reg_rm;
        c.shift_type    = w.shift_type;
        c.shift_amount  = w.shift_amount;
        c.shift_use_rrx = rrx;
      end else if (s == 0) begin
        c.b_src           = bsrc_reg_rs;
        c.shift_latch_amt = 1'b1;
        c.pc_rs_add_4     = (w.rs == 4'd15);
      end else if (s == 1) begin
        c.b_src           = bsrc_reg_rm;
        c.shift_type      = w.shift_type;
        c.shift_use_latch = 1'b1;
        c.pc_rn_add_4     = (w.rn == 4'd15);
        c.pc_rm_add_4     = (w.rm == 4'd15);
      end
      if (last) begin
        c.alu_op           = w.opcode;
        c.alu_set_flags    = w.set_flags;
        // Opcodes 8 to 11 only set flags
        c.alu_writeback    = (w.opcode >= 4'd8 && w.opcode <= 4'd11) ? wb_none : wb_reg_rd;
        c.pipeline_advance = 1'b1;
        c.instr_fetch_en   = 1'b1;
        c.incr_writeback   = 1'b1;
        c.addr_src         = addr_pc;
      end
    end else if (w.instr_class inside {class_load, class_store}) begin
      if (s == 0) begin
        c.alu_op         = offset_op;
        c.addr_src       = addr_alu;
        c.instr_fetch_en = 1'b1;
        c.incr_writeback = 1'b1;
        if (w.i) begin
          c.b_src         = bsrc_reg_rm;
          c.shift_type    = w.shift_type;
          c.shift_amount  = w.shift_amount;
          c.shift_use_rrx = rrx;
        end else begin
          c.b_src = bsrc_imm;
          c.b_imm = w.imm12;
        end
        c.alu_disable_op_b = !w.p;
        c.alu_latch_op_b   = base_wb;
      end else if (s == 1) begin
        c.alu_op             = offset_op;
        c.mem_byte           = w.b;
        c.addr_src           = addr_pc;
        c.alu_use_op_b_latch = base_wb;
        c.alu_writeback      = base_wb ? wb_reg_rn : wb_none;
        c.mem_read_en        = (w.instr_class == class_load);
        c.mem_write_en       = (w.instr_class == class_store);
        if (w.instr_class == class_store) begin
          c.b_src            = bsrc_reg_rd;
          c.pipeline_advance = 1'b1;
        end
      end else if (s == 2 && w.instr_class == class_load) begin
        c.alu_op           = alu_mov;
        c.b_src            = bsrc_read_data;
        c.alu_writeback    = wb_reg_rd;
        c.mem_byte         = w.b;
        c.addr_src         = addr_pc;
        c.pipeline_advance = 1'b1;
      end
    end
    return c;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Random word with r15 and ror #0 drawn more often than uniform
  task automatic draw_word(output decoded_word_t w);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;

    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    w  = '0;
    w.instr_class    = instr_class_e'(r0[31:29] % 3'd5);
    w.condition_pass = (r0[28:26] != 3'd0);
    w.rd             = (r1[28:27] == 2'd0) ? 4'd15 : r0[3:0];
    w.rn             = (r1[1:0] == 2'd0) ? 4'd15 : r0[7:4];
    w.rm             = (r1[30:29] == 2'd0) ? 4'd15 : r0[11:8];
    w.rs             = (r2[31:30] == 2'd0) ? 4'd15 : r0[15:12];
    w.shift_type     = shift_e'(r1[20:19]);
    w.shift_amount   = r1[21] ? 5'd0 : r1[26:22];
    if (w.instr_class inside {class_load, class_store}) begin
      w.imm12 = r2[11:0];
      {w.p, w.u, w.b, w.w, w.i} = r2[16:12];
    end else begin
      w.opcode    = alu_op_e'(r1[5:2] % 4'd15);
      w.set_flags = r1[6];
      w.imm8      = r1[14:7];
      w.rotate    = r1[18:15];
    end
  endtask

  // ==========================================================================
  // Stimulus driven on the falling edge
  // ==========================================================================

  initial begin : stimulus
    decoded_word_t next_word;
    logic          presented;

    seed       = 32'h9ac3c597;
    word       = '0;
    flush_req  = 1'b0;
    words_done = 0;
    presented  = 1'b0;
    while (words_done < num_words) begin
      @(negedge clk);
      flush_req <= 1'b0;
      if (advance_seen) begin
        if (presented) begin
          words_done++;
        end
        if (words_done < num_words) begin
          draw_word(next_word);
          word <= next_word;
        end
        presented = 1'b1;
      end else if (presented && model_flush_count == 2'd0 && model_step == 1 &&
                   ($random(seed) & 7) == 0) begin
        // Abort a multi-step instruction half way
        flush_req <= 1'b1;
      end
    end
    $display("=== PASS ===");
    $finish;
  end

  // ==========================================================================
  // Compare just before the state update at the rising edge
  // ==========================================================================

  always @(posedge clk) begin : compare
    control_t expected;

    if (reset) begin
      model_flush_count = 2'd3;
      model_step        = '0;
      advance_seen      = 1'b0;
      startup_cycles    = 0;
      startup_done      = 1'b0;
    end else begin
      expected = expected_ctrl(word, model_step, model_flush_count, flush_req);
      // Start-up flush length as seen on the DUT output alone
      if (!startup_done) begin
        startup_cycles++;
        if (control_signals.pipeline_advance) begin
          startup_done = 1'b1;
          check_value("startup_flush_cycles", 64'd3, 64'(startup_cycles));
        end
      end
      check_value($sformatf("control_signals (step %0d)", model_step),
                  64'(expected), 64'(control_signals));
      advance_seen = expected.pipeline_advance;
      if (flush_req) begin
        model_flush_count = 2'd1;
      end else if (model_flush_count != 2'd0) begin
        model_flush_count = model_flush_count - 2'd1;
      end
      model_step = expected.pipeline_advance ? '0 : model_step + 1'b1;
    end
  end

  initial begin : watchdog
    #(timeout_cycles * clk_period_ns);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("=== FAIL ===");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/instr_sequencer.sv
hw/dataproc_ctrl.sv
hw/load_store_ctrl.sv
hw/control_select.sv
hw/control_unit.sv
tb/clock_gen.sv
tb/control_unit_tb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - hw/cpu_isa_pkg.sv
  - hw/cpu_ctrl_pkg.sv
  - hw/instr_sequencer.sv
  - hw/dataproc_ctrl.sv
  - hw/load_store_ctrl.sv
  - hw/control_select.sv
  - hw/control_unit.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/control_unit_tb.sv
